/* flist.f */
+incdir+rtl
rtl/ntm_divider_pkg.sv
rtl/ntm_scalar_divider.sv
rtl/ntm_vector_divider.sv
rtl/ntm_matrix_divider.sv
rtl/ntm_divider_top.sv
sim/tb_ntm_divider.sv

/* Bender.yml */
package:
  name: ntm_divider

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ntm_divider_pkg.sv
      - rtl/ntm_scalar_divider.sv
      - rtl/ntm_vector_divider.sv
      - rtl/ntm_matrix_divider.sv
      - rtl/ntm_divider_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_ntm_divider.sv

/* sim/tb_ntm_divider.sv */
////////////////////////////////////////
// Matrix divider testbench
////////////////////////////////////////

`timescale 1ns/1ps

`include "ntm_divider_settings.svh"

module tb_ntm_divider import ntm_divider_pkg::*; ();

  localparam int result_timeout = 200;
  localparam int num_matrices   = 12;

  logic        CLK;
  logic        RST;
  logic        start;
  logic        ready;
  index_t      size_i_in;
  index_t      size_j_in;
  logic        data_a_in_enable;
  logic        data_b_in_enable;
  data_t       data_a_in;
  data_t       data_b_in;
  logic        data_out_i_enable;
  logic        data_out_j_enable;
  div_result_t data_out;

  // Error counters
  int mismatch_count = 0;
  int timeout_count  = 0;
  int other_count    = 0;

  // Strobe counts seen by the monitor
  int col_strobes  = 0;
  int row_strobes  = 0;
  int ready_pulses = 0;

  // Stimulus coverage
  int       zero_div_seen = 0;
  int       big_div_seen  = 0;
  logic [2:0] orders_seen = '0;

  logic [31:0] lcg_state = 32'h12e71ad1;

  ntm_divider_top u_dut (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .size_i_in         (size_i_in),
    .size_j_in         (size_j_in),
    .data_a_in_enable  (data_a_in_enable),
    .data_b_in_enable  (data_b_in_enable),
    .data_a_in         (data_a_in),
    .data_b_in         (data_b_in),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .data_out          (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits of the LCG are the better ones
  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return (r >> 16) % n;
  endfunction

  // Reference quotient and remainder
  function automatic div_result_t model_div(input data_t a, input data_t b);
    div_result_t r;
    if (b == '0) begin
      r.quotient  = '1;
      r.remainder = a;
    end else begin
      r.quotient  = a / b;
      r.remainder = a % b;
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
    mismatch_count++;
  endtask

  // Mix of zero, oversized, small and full-range divisors
  task automatic pick_operands(output data_t a, output data_t b);
    int unsigned kind;
    kind = rand_below(6);
    a    = data_t'(next_rand() >> 8);
    case (kind)
      0: b = '0;
      1: begin
        a = a >> 1;
        b = a + data_t'(1) + data_t'(next_rand() >> 20);
      end
      2: b = data_t'(rand_below(16));
      default: b = data_t'(next_rand() >> 16);
    endcase
    if (b == '0) zero_div_seen++;
    if (b > a) big_div_seen++;
  endtask

  task automatic begin_matrix(input index_t si, input index_t sj);
    @(posedge CLK);
    size_i_in <= si;
    size_j_in <= sj;
    start     <= 1'b1;
    @(posedge CLK);
    start     <= 1'b0;
  endtask

  // Start pulse mid-matrix with a different shape
  task automatic stray_start(input index_t si, input index_t sj);
    @(posedge CLK);
    size_i_in <= si + index_t'(1);
    size_j_in <= sj + index_t'(1);
    start     <= 1'b1;
    @(posedge CLK);
    start     <= 1'b0;
  endtask

  // Order 0 is A then B, 1 is B then A, 2 is both together
  task automatic drive_pair(input data_t a, input data_t b, input int unsigned order,
                            input int unsigned gap, input int unsigned pre);
    repeat (pre) @(posedge CLK);
    @(posedge CLK);
    data_a_in <= a;
    data_b_in <= b;
    if (order != 1) data_a_in_enable <= 1'b1;
    if (order != 0) data_b_in_enable <= 1'b1;
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
    if (order != 2) begin
      repeat (gap) @(posedge CLK);
      if (order == 0) data_b_in_enable <= 1'b1;
      else data_a_in_enable <= 1'b1;
      @(posedge CLK);
      data_a_in_enable <= 1'b0;
      data_b_in_enable <= 1'b0;
    end
  endtask

  task automatic wait_result(output logic found);
    int cycles;
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < result_timeout) begin
      @(negedge CLK);
      cycles++;
      if (data_out_j_enable) found = 1'b1;
    end
    if (!found) begin
      $display("TIMEOUT at %0t: no column strobe within %0d cycles", $time, result_timeout);
      timeout_count++;
    end
  endtask

  ////////////////////////////////////////
  // One matrix in row-major order
  ////////////////////////////////////////

  task automatic run_matrix(input int mat_idx);
    index_t      si;
    index_t      sj;
    data_t       a;
    data_t       b;
    div_result_t exp;
    int unsigned order;
    int unsigned gap;
    int unsigned pre;
    int          i;
    int          j;
    int          col_base;
    int          row_base;
    int          rdy_base;
    logic        found;
    logic        last;
    si       = index_t'(1 + rand_below(4));
    sj       = index_t'(1 + rand_below(4));
    col_base = col_strobes;
    row_base = row_strobes;
    rdy_base = ready_pulses;
    begin_matrix(si, sj);
    for (i = 0; i < int'(si); i++) begin
      for (j = 0; j < int'(sj); j++) begin
        pick_operands(a, b);
        order = rand_below(3);
        gap   = rand_below(4);
        pre   = rand_below(3);
        orders_seen[order] = 1'b1;
        exp = model_div(a, b);
        drive_pair(a, b, order, gap, pre);
        if (mat_idx % 2 == 1 && i == 0 && j == 0) stray_start(si, sj);
        wait_result(found);
        if (found) begin
          last = (i == int'(si) - 1) && (j == int'(sj) - 1);
          if (data_out !== exp) report_mismatch("data_out", exp, data_out);
          // Row strobe only on the last column
          if (data_out_i_enable !== (j == int'(sj) - 1)) begin
            report_mismatch("data_out_i_enable", (j == int'(sj) - 1), data_out_i_enable);
          end
          if (ready !== 1'b0) report_mismatch("ready", 0, ready);
          @(negedge CLK);
          if (ready !== last) report_mismatch("ready", last, ready);
        end
      end
    end
    repeat (4) @(negedge CLK);
    if (col_strobes - col_base != int'(si) * int'(sj)) begin
      report_mismatch("column strobe count", int'(si) * int'(sj), col_strobes - col_base);
    end
    if (row_strobes - row_base != int'(si)) begin
      report_mismatch("row strobe count", si, row_strobes - row_base);
    end
    if (ready_pulses - rdy_base != 1) begin
      report_mismatch("ready pulse count", 1, ready_pulses - rdy_base);
    end
  endtask

  // Strobe monitor
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_j_enable) col_strobes++;
      if (data_out_i_enable) row_strobes++;
      if (ready) ready_pulses++;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    RST              <= 1'b1;
    start            <= 1'b0;
    size_i_in        <= '0;
    size_j_in        <= '0;
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
    data_a_in        <= '0;
    data_b_in        <= '0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;

    // Quiet outputs after reset
    repeat (8) begin
      @(negedge CLK);
      if (ready !== 1'b0) report_mismatch("ready", 0, ready);
      if (data_out_i_enable !== 1'b0) report_mismatch("data_out_i_enable", 0, data_out_i_enable);
      if (data_out_j_enable !== 1'b0) report_mismatch("data_out_j_enable", 0, data_out_j_enable);
      if (data_out !== '0) report_mismatch("data_out", 0, data_out);
    end

    for (int m = 0; m < num_matrices; m++) begin
      run_matrix(m);
    end

    if (zero_div_seen == 0 || big_div_seen == 0) begin
      $display("Stimulus never produced a zero divisor or an oversized divisor");
      other_count++;
    end
    if (orders_seen != 3'b111) begin
      $display("Stimulus did not cover every strobe order");
      other_count++;
    end

    $display("Summary: %0d mismatches, %0d timeouts, %0d other errors",
             mismatch_count, timeout_count, other_count);
    if (mismatch_count + timeout_count + other_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* rtl/ntm_divider_top.sv */
////////////////////////////////////////
// Matrix divider top
////////////////////////////////////////

`timescale 1ns/1ps

module ntm_divider_top import ntm_divider_pkg::*; (
  input  logic        CLK,
  input  logic        RST,

  // Matrix control
  input  logic        start,
  output logic        ready,

  // Shape
  input  index_t      size_i_in,
  input  index_t      size_j_in,

  // Element input
  input  logic        data_a_in_enable,
  input  logic        data_b_in_enable,
  input  data_t       data_a_in,
  input  data_t       data_b_in,

  // Element output
  output logic        data_out_i_enable,
  output logic        data_out_j_enable,
  output div_result_t data_out
);

  // Matrix sequencer owns all the control
  ntm_matrix_divider u_matrix_divider (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .size_i_in         (size_i_in),
    .size_j_in         (size_j_in),
    .data_a_in_enable  (data_a_in_enable),
    .data_b_in_enable  (data_b_in_enable),
    .data_a_in         (data_a_in),
    .data_b_in         (data_b_in),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .data_out          (data_out)
  );

endmodule

/* rtl/ntm_matrix_divider.sv */
////////////////////////////////////////
// Matrix sequencer for the divider
////////////////////////////////////////

`timescale 1ns/1ps

module ntm_matrix_divider import ntm_divider_pkg::*; (
  input  logic        CLK,
  input  logic        RST,

  // Matrix control
  input  logic        start,
  output logic        ready,

  // Shape sampled at start
  input  index_t      size_i_in,
  input  index_t      size_j_in,

  // Element input
  input  logic        data_a_in_enable,
  input  logic        data_b_in_enable,
  input  data_t       data_a_in,
  input  data_t       data_b_in,

  // Element output with row and column strobes
  output logic        data_out_i_enable,
  output logic        data_out_j_enable,
  output div_result_t data_out
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  matrix_state_t state;

  // Stored shape
  index_t size_i_q;
  index_t size_j_q;
  index_t row_cnt;

  // Last row done while the output drains
  logic last_pending;

  // Row walker link
  logic        row_start;
  logic        elem_done;
  logic        row_done;
  div_result_t elem_result;

  // One cycle in the row state gives the start pulse
  assign row_start = (state == mat_row);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= mat_idle;
      size_i_q     <= '0;
      size_j_q     <= '0;
      row_cnt      <= '0;
      last_pending <= 1'b0;
      ready        <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        mat_idle: begin
          // Start only counts here
          if (start) begin
            size_i_q     <= size_i_in;
            size_j_q     <= size_j_in;
            row_cnt      <= '0;
            last_pending <= 1'b0;
            state        <= mat_row;
          end
        end
        mat_row: begin
          state <= mat_wait_row;
        end
        mat_wait_row: begin
          if (last_pending) begin
            // Final column strobe went out last cycle
            ready        <= 1'b1;
            last_pending <= 1'b0;
            state        <= mat_idle;
          end else if (row_done) begin
            if (row_cnt == size_i_q - 1'b1) begin
              last_pending <= 1'b1;
            end else begin
              row_cnt <= row_cnt + 1'b1;
              state   <= mat_row;
            end
          end
        end
        default: state <= mat_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////

  // Strobes trail the row walker by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out          <= '0;
    end else begin
      data_out_j_enable <= elem_done;
      // Row done coincides with last element done
      data_out_i_enable <= row_done;
      if (elem_done) begin
        data_out <= elem_result;
      end
    end
  end

  ////////////////////////////////////////
  // Row walker
  ////////////////////////////////////////

  ntm_vector_divider u_vector_divider (
    .CLK              (CLK),
    .RST              (RST),
    .row_start        (row_start),
    .row_size         (size_j_q),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in_enable (data_b_in_enable),
    .data_a_in        (data_a_in),
    .data_b_in        (data_b_in),
    .elem_done        (elem_done),
    .row_done         (row_done),
    .elem_result      (elem_result)
  );

endmodule

/* rtl/ntm_vector_divider.sv */
////////////////////////////////////////
// Row sequencer for the divider
////////////////////////////////////////

`timescale 1ns/1ps

module ntm_vector_divider import ntm_divider_pkg::*; (
  input  logic        CLK,
  input  logic        RST,

  // Row control
  input  logic        row_start,
  input  index_t      row_size,

  // Element strobes and values
  input  logic        data_a_in_enable,
  input  logic        data_b_in_enable,
  input  data_t       data_a_in,
  input  data_t       data_b_in,

  // Per element and per row results
  output logic        elem_done,
  output logic        row_done,
  output div_result_t elem_result
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  vector_state_t state;
  index_t        size_q;
  index_t        col_cnt;

  // Halves already latched
  logic a_valid;
  logic b_valid;
  // Half present after this cycle
  logic a_have;
  logic b_have;

  // Scalar divider link
  logic          div_start;
  div_operands_t operands_q;
  logic          div_ready;
  div_result_t   div_result;

  assign a_have = a_valid | data_a_in_enable;
  assign b_have = b_valid | data_b_in_enable;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= vec_idle;
      size_q    <= '0;
      col_cnt   <= '0;
      a_valid   <= 1'b0;
      b_valid   <= 1'b0;
      div_start <= 1'b0;
      elem_done <= 1'b0;
      row_done  <= 1'b0;
    end else begin
      div_start <= 1'b0;
      elem_done <= 1'b0;
      row_done  <= 1'b0;
      case (state)
        vec_idle: begin
          if (row_start) begin
            size_q  <= row_size;
            col_cnt <= '0;
            a_valid <= 1'b0;
            b_valid <= 1'b0;
            state   <= vec_collect;
          end
        end
        vec_collect: begin
          // Launch as soon as the pair is complete
          if (a_have && b_have) begin
            a_valid   <= 1'b0;
            b_valid   <= 1'b0;
            div_start <= 1'b1;
            state     <= vec_divide;
          end else begin
            a_valid <= a_have;
            b_valid <= b_have;
          end
        end
        vec_divide: begin
          if (div_ready) begin
            elem_done <= 1'b1;
            // Last column closes the row
            if (col_cnt == size_q - 1'b1) begin
              row_done <= 1'b1;
              state    <= vec_idle;
            end else begin
              col_cnt <= col_cnt + 1'b1;
              state   <= vec_collect;
            end
          end
        end
        default: state <= vec_idle;
      endcase
    end
  end

  // Operands latch only while collecting
  always_ff @(posedge CLK) begin
    if (state == vec_collect) begin
      if (data_a_in_enable) begin
        operands_q.dividend <= data_a_in;
      end
      if (data_b_in_enable) begin
        operands_q.divisor <= data_b_in;
      end
    end
    if (state == vec_divide && div_ready) begin
      elem_result <= div_result;
    end
  end

  ////////////////////////////////////////
  // Scalar divider
  ////////////////////////////////////////

  ntm_scalar_divider u_scalar_divider (
    .CLK          (CLK),
    .RST          (RST),
    .div_start    (div_start),
    .div_operands (operands_q),
    .div_ready    (div_ready),
    .div_result   (div_result)
  );

endmodule

/* rtl/ntm_scalar_divider.sv */
////////////////////////////////////////
// Scalar restoring divider
////////////////////////////////////////

`timescale 1ns/1ps

`include "ntm_divider_settings.svh"

module ntm_scalar_divider import ntm_divider_pkg::*; (
  input  logic          CLK,
  input  logic          RST,

  // Launch with operands
  input  logic          div_start,
  input  div_operands_t div_operands,

  // One pulse when the result is valid
  output logic          div_ready,
  output div_result_t   div_result
);

  // Counter wide enough to hold the element width
  localparam int unsigned cnt_w = $clog2(`NTM_DATA_SIZE + 1);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic             busy;
  logic [cnt_w-1:0] bit_cnt;

  // Working registers
  data_t divisor_q;
  data_t quo_q;
  data_t rem_q;

  // One trial step
  logic [`NTM_DATA_SIZE:0]   shifted;
  logic [`NTM_DATA_SIZE+1:0] trial;
  data_t                     rem_next;
  data_t                     quo_next;

  ////////////////////////////////////////
  // Trial subtraction
  ////////////////////////////////////////

  always_comb begin
    // Next dividend bit enters the partial remainder
    shifted = {rem_q, quo_q[`NTM_DATA_SIZE-1]};
    trial   = {1'b0, shifted} - {2'b00, divisor_q};
    // Top bit set means the divisor did not fit
    if (trial[`NTM_DATA_SIZE+1]) begin
      rem_next = shifted[`NTM_DATA_SIZE-1:0];
      quo_next = {quo_q[`NTM_DATA_SIZE-2:0], 1'b0};
    end else begin
      rem_next = trial[`NTM_DATA_SIZE-1:0];
      quo_next = {quo_q[`NTM_DATA_SIZE-2:0], 1'b1};
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      bit_cnt   <= '0;
      div_ready <= 1'b0;
    end else begin
      div_ready <= 1'b0;
      if (div_start) begin
        busy    <= 1'b1;
        bit_cnt <= cnt_w'(`NTM_DATA_SIZE);
      end else if (busy) begin
        bit_cnt <= bit_cnt - 1'b1;
        // Final bit this cycle
        if (bit_cnt == cnt_w'(1)) begin
          busy      <= 1'b0;
          div_ready <= 1'b1;
        end
      end
    end
  end

  // One quotient bit per cycle
  always_ff @(posedge CLK) begin
    if (div_start) begin
      divisor_q <= div_operands.divisor;
      quo_q     <= div_operands.dividend;
      rem_q     <= '0;
    end else if (busy) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
      if (bit_cnt == cnt_w'(1)) begin
        div_result.quotient  <= quo_next;
        div_result.remainder <= rem_next;
      end
    end
  end

endmodule

/* rtl/ntm_divider_pkg.sv */
////////////////////////////////////////
// Matrix divider types
////////////////////////////////////////

package ntm_divider_pkg;

  `include "ntm_divider_settings.svh"

  // One unsigned matrix element
  typedef logic [`NTM_DATA_SIZE-1:0] data_t;

  // Row or column count and size
  typedef logic [`NTM_INDEX_SIZE-1:0] index_t;

  // Pair handed to the scalar divider
  typedef struct packed {
    data_t dividend;
    data_t divisor;
  } div_operands_t;

  // Quotient and remainder of one element
  typedef struct packed {
    data_t quotient;
    data_t remainder;
  } div_result_t;

  // Row walker states
  typedef enum logic [1:0] {
    vec_idle,
    vec_collect,
    vec_divide
  } vector_state_t;

  // Matrix walker states
  typedef enum logic [1:0] {
    mat_idle,
    mat_row,
    mat_wait_row
  } matrix_state_t;

endpackage

/* rtl/ntm_divider_settings.svh */
////////////////////////////////////////
// Matrix divider widths
////////////////////////////////////////

`ifndef NTM_DIVIDER_SETTINGS_SVH
`define NTM_DIVIDER_SETTINGS_SVH

// Width of one matrix element
// Also sets the divider iteration count
`define NTM_DATA_SIZE 16

// Width of row and column counts
// Sizes must be at least 1
`define NTM_INDEX_SIZE 8

`endif
